/* flist.f */
+incdir+include
source/axil_sram_pkg.sv
source/skid_buffer.sv
source/sram_core.sv
source/axil_sram_bridge.sv
source/axil_sram_top.sv
sim/axil_sram_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module axil_sram_tb \
  --Mdir obj_dir -o axil_sram_sim \
  -f flist.f

./obj_dir/axil_sram_sim | tee sim.log

# the run passes only if the testbench reported a pass
grep -qx "Simulation passed" sim.log

/* include/axil_sram_tb_tasks.svh */
`ifndef AXIL_SRAM_TB_TASKS_SVH
`define AXIL_SRAM_TB_TASKS_SVH

  // expected memory contents as seen by the manager
  axil_data_t ref_mem [SRAM_DEPTH];

  // byte offset bits are dropped to form the word address
  function automatic sram_addr_t word_of(input axil_addr_t addr);
    return addr[AXIL_ADDR_W-1:ADDR_LSB];
  endfunction

  function automatic void model_write(input axil_addr_t addr, input axil_data_t data,
                                      input axil_strb_t strb);
    for (int lane = 0; lane < AXIL_STRB_W; lane++) begin
      if (strb[lane]) begin
        ref_mem[word_of(addr)][lane*8 +: 8] = data[lane*8 +: 8];
      end
    end
  endfunction

  task automatic check_data(input string name, input axil_data_t exp, input axil_data_t act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
      error_count++;
    end
  endtask

  // address and data go out together and each valid drops on its own handshake
  task automatic send_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb);
    logic aw_fire;
    logic w_fire;
    i_awaddr  = addr;
    i_awvalid = 1'b1;
    i_wdata   = data;
    i_wstrb   = strb;
    i_wvalid  = 1'b1;
    while (i_awvalid || i_wvalid) begin
      @(negedge clk);
      aw_fire = i_awvalid && o_awready;
      w_fire  = i_wvalid && o_wready;
      @(posedge clk);
      #1;
      i_awvalid = i_awvalid && !aw_fire;
      i_wvalid  = i_wvalid && !w_fire;
    end
  endtask

  task automatic send_read(input axil_addr_t addr);
    logic fire;
    i_araddr  = addr;
    i_arvalid = 1'b1;
    while (i_arvalid) begin
      @(negedge clk);
      fire = o_arready;
      @(posedge clk);
      #1;
      i_arvalid = !fire;
    end
  endtask

  task automatic take_bresp(output axil_resp_t resp);
    logic fire;
    fire     = 1'b0;
    i_bready = 1'b1;
    while (!fire) begin
      @(negedge clk);
      fire = o_bvalid;
      resp = o_bresp;
      @(posedge clk);
      #1;
    end
    i_bready = 1'b0;
  endtask

  task automatic take_rdata(output axil_data_t data, output axil_resp_t resp);
    logic fire;
    fire     = 1'b0;
    i_rready = 1'b1;
    while (!fire) begin
      @(negedge clk);
      fire = o_rvalid;
      data = o_rdata;
      resp = o_rresp;
      @(posedge clk);
      #1;
    end
    i_rready = 1'b0;
  endtask

  task automatic write_word(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb);
    axil_resp_t resp;
    model_write(addr, data, strb);
    send_write(addr, data, strb);
    take_bresp(resp);
    check_resp("o_bresp", RESP_OKAY, resp);
  endtask

  task automatic read_word(input axil_addr_t addr);
    axil_data_t data;
    axil_resp_t resp;
    send_read(addr);
    take_rdata(data, resp);
    check_data("o_rdata", ref_mem[word_of(addr)], data);
    check_resp("o_rresp", RESP_OKAY, resp);
  endtask

  // eight transfers while bready or rready stays low for a random stretch
  task automatic burst(input logic do_write, input axil_addr_t base);
    int         hold;
    logic       stalled;
    axil_data_t data;
    axil_resp_t resp;
    hold    = 8 + int'($urandom() % 8);
    stalled = 1'b0;
    if (do_write) begin
      for (int i = 0; i < BURST_LEN; i++) begin
        model_write(base + axil_addr_t'(4 * i), $urandom(), '1);
      end
    end
    fork
      for (int i = 0; i < BURST_LEN; i++) begin
        if (do_write) begin
          send_write(base + axil_addr_t'(4 * i), ref_mem[word_of(base + axil_addr_t'(4 * i))], '1);
        end else begin
          send_read(base + axil_addr_t'(4 * i));
        end
      end
      begin
        // the request side has to stall at least once during the hold
        repeat (hold) begin
          @(negedge clk);
          if (do_write) begin
            stalled = stalled || (!o_awready && !o_wready);
          end else begin
            stalled = stalled || !o_arready;
          end
          @(posedge clk);
        end
        #1;
        if (!stalled) begin
          $display("ERROR: ready never fell while responses were held, time %0t", $time);
          error_count++;
        end
        for (int i = 0; i < BURST_LEN; i++) begin
          if (do_write) begin
            take_bresp(resp);
            check_resp("o_bresp", RESP_OKAY, resp);
          end else begin
            take_rdata(data, resp);
            check_data("o_rdata", ref_mem[word_of(base + axil_addr_t'(4 * i))], data);
            check_resp("o_rresp", RESP_OKAY, resp);
          end
        end
      end
    join
  endtask

`endif

/* sim/axil_sram_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_sram_tb;

  import axil_sram_pkg::*;

  localparam int BURST_LEN      = 8;
  // roughly ten times what the whole test sequence needs
  localparam int TIMEOUT_CYCLES = 3000;

  logic       clk;
  logic       rst_n;
  axil_addr_t i_awaddr;
  logic       i_awvalid;
  logic       o_awready;
  axil_data_t i_wdata;
  axil_strb_t i_wstrb;
  logic       i_wvalid;
  logic       o_wready;
  axil_resp_t o_bresp;
  logic       o_bvalid;
  logic       i_bready;
  axil_addr_t i_araddr;
  logic       i_arvalid;
  logic       o_arready;
  axil_data_t o_rdata;
  axil_resp_t o_rresp;
  logic       o_rvalid;
  logic       i_rready;

  int error_count;
  int tests_passed;
  int tests_failed;
  int cycles;

  axil_sram_top uut (.*);

  `include "axil_sram_tb_tasks.svh"

  always #10 clk = ~clk;

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("ERROR: a handshake never completed, run stopped after %0d cycles", cycles);
    $display("Simulation failed");
    $finish;
  end

  task automatic end_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
      tests_passed++;
      $display("test %s: PASS", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL with %0d errors", name, error_count - errs_before);
    end
  endtask

  task automatic test_reset_readback();
    int errs;
    errs = error_count;
    check_flag("o_bvalid", 1'b0, o_bvalid);
    check_flag("o_rvalid", 1'b0, o_rvalid);
    write_word(8'h10, $urandom(), 4'hf);
    read_word(8'h10);
    end_test("reset_readback", errs);
  endtask

  task automatic test_strobes();
    int errs;
    errs = error_count;
    write_word(8'h14, $urandom(), 4'hf);
    // alternating lanes, then the top lane alone
    write_word(8'h14, $urandom(), 4'b0101);
    read_word(8'h14);
    write_word(8'h14, $urandom(), 4'b1000);
    read_word(8'h14);
    end_test("byte_strobes", errs);
  endtask

  task automatic test_addr_alias();
    int errs;
    errs = error_count;
    write_word(8'h23, $urandom(), 4'hf);
    read_word(8'h20);
    read_word(8'h21);
    write_word(8'h22, $urandom(), 4'b0010);
    read_word(8'h23);
    end_test("address_conversion", errs);
  endtask

  task automatic test_backpressure();
    int errs;
    errs = error_count;
    burst(1'b1, 8'h80);
    // nothing may be left once the eighth response is taken
    check_flag("o_bvalid", 1'b0, o_bvalid);
    burst(1'b0, 8'h80);
    check_flag("o_rvalid", 1'b0, o_rvalid);
    end_test("back_pressure", errs);
  endtask

  task automatic test_concurrent();
    int errs;
    errs = error_count;
    // reads hit words from the burst test, writes go to fresh words
    fork
      for (int i = 0; i < BURST_LEN; i++) begin
        write_word(axil_addr_t'(8'hc0 + 4 * i), $urandom(), 4'hf);
      end
      for (int i = 0; i < BURST_LEN; i++) begin
        read_word(axil_addr_t'(8'h80 + 4 * i));
      end
    join
    for (int i = 0; i < BURST_LEN; i++) begin
      read_word(axil_addr_t'(8'hc0 + 4 * i));
    end
    end_test("concurrent_traffic", errs);
  endtask

  initial begin
    void'($urandom(16814));
    clk          = 1'b0;
    rst_n        = 1'b0;
    i_awaddr     = '0;
    i_awvalid    = 1'b0;
    i_wdata      = '0;
    i_wstrb      = '0;
    i_wvalid     = 1'b0;
    i_bready     = 1'b0;
    i_araddr     = '0;
    i_arvalid    = 1'b0;
    i_rready     = 1'b0;
    error_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_readback();
    test_strobes();
    test_addr_alias();
    test_backpressure();
    test_concurrent();
    $display("tests passed=%0d failed=%0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/axil_sram_top.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_sram_top (
  input  logic                      clk,
  input  logic                      rst_n,

  input  axil_sram_pkg::axil_addr_t i_awaddr,
  input  logic                      i_awvalid,
  output logic                      o_awready,
  input  axil_sram_pkg::axil_data_t i_wdata,
  input  axil_sram_pkg::axil_strb_t i_wstrb,
  input  logic                      i_wvalid,
  output logic                      o_wready,
  output axil_sram_pkg::axil_resp_t o_bresp,
  output logic                      o_bvalid,
  input  logic                      i_bready,

  input  axil_sram_pkg::axil_addr_t i_araddr,
  input  logic                      i_arvalid,
  output logic                      o_arready,
  output axil_sram_pkg::axil_data_t o_rdata,
  output axil_sram_pkg::axil_resp_t o_rresp,
  output logic                      o_rvalid,
  input  logic                      i_rready
);

  import axil_sram_pkg::*;

  // bridge to memory command and read response paths
  logic       cmd_valid;
  logic       cmd_ready;
  sram_addr_t cmd_addr;
  logic       cmd_wr_en;
  axil_data_t cmd_wr_data;
  axil_strb_t cmd_wr_strb;
  logic       resp_valid;
  logic       resp_ready;
  axil_data_t resp_data;

  axil_sram_bridge u_bridge (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_awaddr      (i_awaddr),
    .i_awvalid     (i_awvalid),
    .o_awready     (o_awready),
    .i_wdata       (i_wdata),
    .i_wstrb       (i_wstrb),
    .i_wvalid      (i_wvalid),
    .o_wready      (o_wready),
    .o_bresp       (o_bresp),
    .o_bvalid      (o_bvalid),
    .i_bready      (i_bready),
    .i_araddr      (i_araddr),
    .i_arvalid     (i_arvalid),
    .o_arready     (o_arready),
    .o_rdata       (o_rdata),
    .o_rresp       (o_rresp),
    .o_rvalid      (o_rvalid),
    .i_rready      (i_rready),
    .o_cmd_valid   (cmd_valid),
    .i_cmd_ready   (cmd_ready),
    .o_cmd_addr    (cmd_addr),
    .o_cmd_wr_en   (cmd_wr_en),
    .o_cmd_wr_data (cmd_wr_data),
    .o_cmd_wr_strb (cmd_wr_strb),
    .i_resp_valid  (resp_valid),
    .i_resp_data   (resp_data),
    .o_resp_ready  (resp_ready)
  );

  sram_core u_sram (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_cmd_valid   (cmd_valid),
    .o_cmd_ready   (cmd_ready),
    .i_cmd_addr    (cmd_addr),
    .i_cmd_wr_en   (cmd_wr_en),
    .i_cmd_wr_data (cmd_wr_data),
    .i_cmd_wr_strb (cmd_wr_strb),
    .o_resp_valid  (resp_valid),
    .i_resp_ready  (resp_ready),
    .o_resp_data   (resp_data)
  );

endmodule

`default_nettype wire

/* source/axil_sram_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_sram_bridge (
  input  logic                     clk,
  input  logic                     rst_n,

  input  axil_sram_pkg::axil_addr_t i_awaddr,
  input  logic                     i_awvalid,
  output logic                     o_awready,
  input  axil_sram_pkg::axil_data_t i_wdata,
  input  axil_sram_pkg::axil_strb_t i_wstrb,
  input  logic                     i_wvalid,
  output logic                     o_wready,
  output axil_sram_pkg::axil_resp_t o_bresp,
  output logic                     o_bvalid,
  input  logic                     i_bready,

  input  axil_sram_pkg::axil_addr_t i_araddr,
  input  logic                     i_arvalid,
  output logic                     o_arready,
  output axil_sram_pkg::axil_data_t o_rdata,
  output axil_sram_pkg::axil_resp_t o_rresp,
  output logic                     o_rvalid,
  input  logic                     i_rready,

  output logic                     o_cmd_valid,
  input  logic                     i_cmd_ready,
  output axil_sram_pkg::sram_addr_t o_cmd_addr,
  output logic                     o_cmd_wr_en,
  output axil_sram_pkg::axil_data_t o_cmd_wr_data,
  output axil_sram_pkg::axil_strb_t o_cmd_wr_strb,
  input  logic                     i_resp_valid,
  input  axil_sram_pkg::axil_data_t i_resp_data,
  output logic                     o_resp_ready
);

  import axil_sram_pkg::*;

  logic        sb_ar_valid;
  logic        sb_ar_ready;
  sram_addr_t  sb_ar_addr;
  logic        sb_r_ready;
  logic        sb_aw_valid;
  sram_addr_t  sb_aw_addr;
  logic        sb_w_valid;
  wr_payload_t w_in;
  wr_payload_t sb_w;

  logic        pri_rd;
  logic        issue_en;
  logic        rd_ok;
  logic        wr_ok;
  logic        rd_start;
  logic        wr_start;

  logic [1:0]  bcnt;
  logic [1:0]  bcnt_next;
  logic [1:0]  wr_inflight;
  logic        cmd_wr_acc;
  logic        b_acc;

  // read address, only taken while read data has room
  assign o_arready = sb_ar_ready && sb_r_ready;

  skid_buffer #(.payload_t(sram_addr_t)) u_sb_ar (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_arvalid && sb_r_ready),
    .i_data  (i_araddr[AXIL_ADDR_W-1:ADDR_LSB]),
    .o_ready (sb_ar_ready),
    .o_valid (sb_ar_valid),
    .o_data  (sb_ar_addr),
    .i_ready (rd_start)
  );

  // read data back to the manager
  assign o_rresp      = RESP_OKAY;
  assign o_resp_ready = sb_r_ready;

  skid_buffer #(.payload_t(axil_data_t)) u_sb_r (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_resp_valid),
    .i_data  (i_resp_data),
    .o_ready (sb_r_ready),
    .o_valid (o_rvalid),
    .o_data  (o_rdata),
    .i_ready (i_rready)
  );

  skid_buffer #(.payload_t(sram_addr_t)) u_sb_aw (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_awvalid),
    .i_data  (i_awaddr[AXIL_ADDR_W-1:ADDR_LSB]),
    .o_ready (o_awready),
    .o_valid (sb_aw_valid),
    .o_data  (sb_aw_addr),
    .i_ready (wr_start)
  );

  assign w_in.data = i_wdata;
  assign w_in.strb = i_wstrb;

  skid_buffer #(.payload_t(wr_payload_t)) u_sb_w (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_wvalid),
    .i_data  (w_in),
    .o_ready (o_wready),
    .o_valid (sb_w_valid),
    .o_data  (sb_w),
    .i_ready (wr_start)
  );

  // write response counter, a write is counted once the memory takes it
  assign o_bresp    = RESP_OKAY;
  assign cmd_wr_acc = o_cmd_valid && i_cmd_ready && o_cmd_wr_en;
  assign b_acc      = o_bvalid && i_bready;

  always_comb begin
    case ({cmd_wr_acc, b_acc})
      2'b10:   bcnt_next = bcnt + 2'd1;
      2'b01:   bcnt_next = bcnt - 2'd1;
      default: bcnt_next = bcnt;
    endcase
  end

  // a write still sitting in the command register will also need a response
  assign wr_inflight = bcnt + {1'b0, o_cmd_valid && o_cmd_wr_en};

  assign issue_en = !o_cmd_valid || i_cmd_ready;
  assign rd_ok    = sb_ar_valid && sb_r_ready;
  assign wr_ok    = sb_aw_valid && sb_w_valid && (wr_inflight < 2'd2);

  // alternate priority, loser of the last round goes first
  always_comb begin
    rd_start = 1'b0;
    wr_start = 1'b0;
    if (issue_en) begin
      if (rd_ok && (pri_rd || !wr_ok)) begin
        rd_start = 1'b1;
      end else if (wr_ok) begin
        wr_start = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_cmd_valid <= 1'b0;
      pri_rd      <= 1'b0;
      bcnt        <= 2'd0;
      o_bvalid    <= 1'b0;
    end else begin
      bcnt     <= bcnt_next;
      o_bvalid <= (bcnt_next != 2'd0);
      if (issue_en) begin
        o_cmd_valid <= rd_start || wr_start;
      end
      if (rd_start) begin
        pri_rd <= 1'b0;
      end else if (wr_start) begin
        pri_rd <= 1'b1;
      end
    end
  end

  // command payload
  always_ff @(posedge clk) begin
    if (rd_start) begin
      o_cmd_addr  <= sb_ar_addr;
      o_cmd_wr_en <= 1'b0;
    end else if (wr_start) begin
      o_cmd_addr    <= sb_aw_addr;
      o_cmd_wr_en   <= 1'b1;
      o_cmd_wr_data <= sb_w.data;
      o_cmd_wr_strb <= sb_w.strb;
    end
  end

  a_bcnt_max: assert property (@(posedge clk) disable iff (!rst_n)
    bcnt <= 2'd2);

  a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (o_cmd_valid && !i_cmd_ready) |=>
      (o_cmd_valid && $stable({o_cmd_addr, o_cmd_wr_en, o_cmd_wr_data, o_cmd_wr_strb})));

endmodule

`default_nettype wire

/* source/sram_core.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_core (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      i_cmd_valid,
  output logic                      o_cmd_ready,
  input  axil_sram_pkg::sram_addr_t i_cmd_addr,
  input  logic                      i_cmd_wr_en,
  input  axil_sram_pkg::axil_data_t i_cmd_wr_data,
  input  axil_sram_pkg::axil_strb_t i_cmd_wr_strb,

  output logic                      o_resp_valid,
  input  logic                      i_resp_ready,
  output axil_sram_pkg::axil_data_t o_resp_data
);

  import axil_sram_pkg::*;

  axil_data_t mem [SRAM_DEPTH];

  logic cmd_acc;
  logic rd_acc;

  // a held response blocks new commands until it drains
  assign o_cmd_ready = !o_resp_valid || i_resp_ready;
  assign cmd_acc     = i_cmd_valid && o_cmd_ready;
  assign rd_acc      = cmd_acc && !i_cmd_wr_en;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_resp_valid <= 1'b0;
    end else if (rd_acc) begin
      o_resp_valid <= 1'b1;
    end else if (i_resp_ready) begin
      o_resp_valid <= 1'b0;
    end
  end

  // byte lane writes, one lane per strobe bit
  always_ff @(posedge clk) begin
    if (cmd_acc && i_cmd_wr_en) begin
      for (int lane = 0; lane < AXIL_STRB_W; lane++) begin
        if (i_cmd_wr_strb[lane]) begin
          mem[i_cmd_addr][lane*8 +: 8] <= i_cmd_wr_data[lane*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_acc) begin
      o_resp_data <= mem[i_cmd_addr];
    end
  end

  a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (o_resp_valid && !i_resp_ready) |=> (o_resp_valid && $stable(o_resp_data)));

endmodule

`default_nettype wire

/* source/skid_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module skid_buffer #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst_n,

  input  logic     i_valid,
  input  payload_t i_data,
  output logic     o_ready,

  output logic     o_valid,
  output payload_t o_data,
  input  logic     i_ready
);

  // two slot ring of payloads
  payload_t   entries [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;

  logic       push;
  logic       pop;

  assign push = i_valid && o_ready;
  assign pop  = o_valid && i_ready;

  // upstream only stalls once both slots are taken
  assign o_ready = (count != 2'd2);
  assign o_valid = (count != 2'd0);
  assign o_data  = entries[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= !wr_ptr;
      end
      if (pop) begin
        rd_ptr <= !rd_ptr;
      end
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= i_data;
    end
  end

  // head item must not move or vanish while the consumer stalls
  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_data)));

  // a push never lands on the unread head entry
  a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
    (push && o_valid) |-> (wr_ptr != rd_ptr));

endmodule

`default_nettype wire

/* source/axil_sram_pkg.sv */
`default_nettype none

package axil_sram_pkg;

  // byte addressed AXI-Lite side
  localparam int AXIL_ADDR_W = 8;
  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

  // byte offset bits inside one data word
  localparam int ADDR_LSB = 2;

  // word addressed memory side
  localparam int SRAM_ADDR_W = AXIL_ADDR_W - ADDR_LSB;
  localparam int SRAM_DEPTH  = 1 << SRAM_ADDR_W;

  typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [AXIL_STRB_W-1:0] axil_strb_t;
  typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;
  typedef logic [1:0]             axil_resp_t;

  // the only response this subsystem ever returns
  localparam axil_resp_t RESP_OKAY = 2'b00;

  // write data channel bundle, one skid buffer entry
  typedef struct packed {
    axil_data_t data;
    axil_strb_t strb;
  } wr_payload_t;

endpackage

`default_nettype wire
